/* verilog/ahb_defs.svh */
`ifndef AHB_DEFS_SVH
`define AHB_DEFS_SVH

// ------------------------------
// bus widths
// ------------------------------
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// transfer length in bytes
`define XFER_CNT_W 16

// ------------------------------
// sram slave
// ------------------------------
`define SRAM_WORDS 4096

// lfsr start value, must be nonzero
`define SRAM_WAIT_SEED 16'hace1

`endif

/* verilog/ahb_pkg.sv */
`default_nettype none

`include "ahb_defs.svh"

package ahb_pkg;

  // width types
  typedef logic [`AHB_ADDR_W-1:0] addr_t;
  typedef logic [`AHB_DATA_W-1:0] data_t;
  typedef logic [`XFER_CNT_W-1:0] byte_cnt_t;
  typedef logic [4:0]             beat_cnt_t;

  // ------------------------------
  // ahb encodings
  // ------------------------------
  typedef enum logic [1:0] {
    TRANS_IDLE   = 2'b00,
    TRANS_BUSY   = 2'b01,
    TRANS_NONSEQ = 2'b10,
    TRANS_SEQ    = 2'b11
  } htrans_e;

  // wrap types left out
  typedef enum logic [2:0] {
    BURST_SINGLE = 3'b000,
    BURST_INCR   = 3'b001,
    BURST_INCR4  = 3'b011,
    BURST_INCR8  = 3'b101,
    BURST_INCR16 = 3'b111
  } hburst_e;

  localparam logic [2:0] HSIZE_WORD = 3'b010;
  localparam logic       HRESP_OKAY = 1'b0;

  // ------------------------------
  // bundles
  // ------------------------------
  typedef struct packed {
    addr_t     start_addr;
    byte_cnt_t byte_cnt;
    logic      wr;
  } xfer_cmd_t;

  typedef struct packed {
    addr_t      haddr;
    data_t      hwdata;
    logic       hwrite;
    logic [2:0] hsize;
    hburst_e    hburst;
    htrans_e    htrans;
  } ahb_req_t;

  typedef struct packed {
    data_t hrdata;
    logic  hready;
    logic  hresp;
  } ahb_rsp_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_BURST,
    ST_DRAIN,
    ST_DONE
  } master_state_e;

endpackage

`default_nettype wire

/* verilog/burst_planner.sv */
`default_nettype none
`timescale 1ns/1ns

module burst_planner
  import ahb_pkg::*;
(
  input  addr_t     addr,
  input  byte_cnt_t words_left,
  output hburst_e   burst,
  output beat_cnt_t beats
);

  // words before the next 1 KB boundary, 1 to 256
  logic [8:0] room;
  logic       fit16;
  logic       fit8;
  logic       fit4;

  assign room = 9'd256 - {1'b0, addr[9:2]};

  // ------------------------------
  // size checks
  // ------------------------------
  assign fit16 = (words_left >= byte_cnt_t'(16)) && (room >= 9'd16);
  assign fit8  = (words_left >= byte_cnt_t'(8))  && (room >= 9'd8);
  assign fit4  = (words_left >= byte_cnt_t'(4))  && (room >= 9'd4);

  // largest burst that fits both limits
  always_comb begin
    if (fit16) begin
      burst = BURST_INCR16;
      beats = beat_cnt_t'(16);
    end else if (fit8) begin
      burst = BURST_INCR8;
      beats = beat_cnt_t'(8);
    end else if (fit4) begin
      burst = BURST_INCR4;
      beats = beat_cnt_t'(4);
    end else begin
      // one word left, or boundary close
      burst = BURST_SINGLE;
      beats = beat_cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

/* verilog/ahb_burst_master.sv */
`default_nettype none
`timescale 1ns/1ns

module ahb_burst_master
  import ahb_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  xfer_cmd_t cmd,
  input  logic      req,
  output logic      req_ack,
  output logic      done,
  input  data_t     wdata,
  output logic      wdata_ready,
  output data_t     rdata,
  output logic      rdata_valid,
  output ahb_req_t  bus_req,
  input  ahb_rsp_t  bus_rsp
);

  master_state_e state_q;

  // latched command, advanced per beat
  addr_t     addr_q;
  byte_cnt_t words_q;
  logic      wr_q;
  beat_cnt_t beats_left_q;

  // registered address phase
  addr_t   haddr_q;
  htrans_e htrans_q;
  hburst_e hburst_q;
  logic    hwrite_q;
  data_t   hwdata_q;

  // outstanding data phase
  logic dphase_q;
  logic dphase_wr_q;

  logic  req_ack_q;
  logic  done_q;
  logic  rvalid_q;
  data_t rdata_q;

  hburst_e   plan_burst;
  beat_cnt_t plan_beats;
  logic      addr_busy;
  logic      rd_done;

  burst_planner u_planner (
    .addr       (addr_q),
    .words_left (words_q),
    .burst      (plan_burst),
    .beats      (plan_beats)
  );

  assign addr_busy   = (htrans_q == TRANS_NONSEQ) || (htrans_q == TRANS_SEQ);
  assign wdata_ready = dphase_q && dphase_wr_q && bus_rsp.hready;
  assign rd_done     = dphase_q && !dphase_wr_q && bus_rsp.hready;

  // ------------------------------
  // command fsm and address phase
  // ------------------------------
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q      <= ST_IDLE;
      addr_q       <= '0;
      words_q      <= '0;
      wr_q         <= 1'b0;
      beats_left_q <= '0;
      haddr_q      <= '0;
      htrans_q     <= TRANS_IDLE;
      hburst_q     <= BURST_SINGLE;
      hwrite_q     <= 1'b0;
      dphase_q     <= 1'b0;
      dphase_wr_q  <= 1'b0;
      req_ack_q    <= 1'b0;
      done_q       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      req_ack_q <= 1'b0;
      done_q    <= 1'b0;
      rvalid_q  <= rd_done;
      // address phase moves into data phase
      if (bus_rsp.hready) begin
        dphase_q    <= addr_busy;
        dphase_wr_q <= hwrite_q;
      end
      case (state_q)
        ST_IDLE: begin
          if (req) begin
            addr_q    <= cmd.start_addr;
            words_q   <= cmd.byte_cnt >> 2;
            wr_q      <= cmd.wr;
            req_ack_q <= 1'b1;
            state_q   <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (bus_rsp.hready) begin
            htrans_q     <= TRANS_NONSEQ;
            haddr_q      <= addr_q;
            hburst_q     <= plan_burst;
            hwrite_q     <= wr_q;
            addr_q       <= addr_q + addr_t'(4);
            words_q      <= words_q - 1'b1;
            beats_left_q <= plan_beats - 1'b1;
            if (plan_beats != beat_cnt_t'(1)) begin
              state_q <= ST_BURST;
            end else if (words_q == byte_cnt_t'(1)) begin
              state_q <= ST_DRAIN;
            end
          end
        end
        ST_BURST: begin
          if (bus_rsp.hready) begin
            htrans_q     <= TRANS_SEQ;
            haddr_q      <= addr_q;
            addr_q       <= addr_q + addr_t'(4);
            words_q      <= words_q - 1'b1;
            beats_left_q <= beats_left_q - 1'b1;
            if (beats_left_q == beat_cnt_t'(1)) begin
              state_q <= (words_q == byte_cnt_t'(1)) ? ST_DRAIN : ST_ADDR;
            end
          end
        end
        ST_DRAIN: begin
          if (bus_rsp.hready) begin
            htrans_q <= TRANS_IDLE;
            // last data phase finishing now
            if (dphase_q && !addr_busy) begin
              state_q <= ST_DONE;
            end
          end
        end
        ST_DONE: begin
          done_q  <= 1'b1;
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // write word for the beat entering its data phase, read word capture
  always_ff @(posedge clk) begin
    if (bus_rsp.hready && addr_busy && hwrite_q) begin
      hwdata_q <= wdata;
    end
    if (rd_done) begin
      rdata_q <= bus_rsp.hrdata;
    end
  end

  always_comb begin
    bus_req.haddr  = haddr_q;
    bus_req.hwdata = hwdata_q;
    bus_req.hwrite = hwrite_q;
    bus_req.hsize  = HSIZE_WORD;
    bus_req.hburst = hburst_q;
    bus_req.htrans = htrans_q;
  end

  assign req_ack     = req_ack_q;
  assign done        = done_q;
  assign rdata       = rdata_q;
  assign rdata_valid = rvalid_q;

endmodule

`default_nettype wire

/* verilog/ahb_sram_slave.sv */
`default_nettype none
`timescale 1ns/1ns

`include "ahb_defs.svh"

module ahb_sram_slave
  import ahb_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  ahb_req_t bus_req,
  output ahb_rsp_t bus_rsp
);

  localparam int IDX_W = $clog2(`SRAM_WORDS);

  typedef logic [IDX_W-1:0] word_idx_t;

  data_t mem [`SRAM_WORDS];

  // registered address phase
  logic      dp_valid_q;
  logic      dp_write_q;
  word_idx_t dp_idx_q;

  // wait cycles left in the current data phase
  logic [1:0]  wait_q;
  logic [15:0] lfsr_q;

  logic       hready;
  logic       addr_valid;
  logic [1:0] wait_pick;

  assign hready     = (wait_q == 2'd0);
  assign addr_valid = hready &&
                      ((bus_req.htrans == TRANS_NONSEQ) || (bus_req.htrans == TRANS_SEQ));

  // 0 to 2 waits, 3 folds to 0
  assign wait_pick = (lfsr_q[1:0] == 2'd3) ? 2'd0 : lfsr_q[1:0];

  // ------------------------------
  // address phase and wait states
  // ------------------------------
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      dp_valid_q <= 1'b0;
      dp_write_q <= 1'b0;
      dp_idx_q   <= '0;
      wait_q     <= 2'd0;
      lfsr_q     <= `SRAM_WAIT_SEED;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      if (!hready) begin
        wait_q <= wait_q - 2'd1;
      end else begin
        dp_valid_q <= addr_valid;
        if (addr_valid) begin
          dp_write_q <= bus_req.hwrite;
          dp_idx_q   <= bus_req.haddr[IDX_W+1:2];
          wait_q     <= wait_pick;
        end
      end
    end
  end

  // write completes on the last data phase cycle
  always_ff @(posedge clk) begin
    if (dp_valid_q && dp_write_q && hready) begin
      mem[dp_idx_q] <= bus_req.hwdata;
    end
  end

  always_comb begin
    bus_rsp.hrdata = mem[dp_idx_q];
    bus_rsp.hready = hready;
    bus_rsp.hresp  = HRESP_OKAY;
  end

endmodule

`default_nettype wire

/* verilog/ahb_xfer_top.sv */
`default_nettype none
`timescale 1ns/1ns

module ahb_xfer_top
  import ahb_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  xfer_cmd_t cmd,
  input  logic      req,
  output logic      req_ack,
  output logic      done,
  input  data_t     wdata,
  output logic      wdata_ready,
  output data_t     rdata,
  output logic      rdata_valid
);

  ahb_req_t bus_req;
  ahb_rsp_t bus_rsp;

  ahb_burst_master u_master (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .req         (req),
    .req_ack     (req_ack),
    .done        (done),
    .wdata       (wdata),
    .wdata_ready (wdata_ready),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp)
  );

  ahb_sram_slave u_sram (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

endmodule

`default_nettype wire

/* tb/ahb_xfer_assertions.sv */
`default_nettype none
`timescale 1ns/1ns

module ahb_xfer_assertions
  import ahb_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input ahb_req_t bus_req,
  input ahb_rsp_t bus_rsp,
  input logic     req_ack,
  input logic     done
);

  beat_cnt_t burst_len;
  beat_cnt_t beats_left_q;
  addr_t     last_addr;

  // assertion failures so far
  int fail_cnt = 0;

  always_comb begin
    case (bus_req.hburst)
      BURST_INCR4:  burst_len = beat_cnt_t'(4);
      BURST_INCR8:  burst_len = beat_cnt_t'(8);
      BURST_INCR16: burst_len = beat_cnt_t'(16);
      default:      burst_len = beat_cnt_t'(1);
    endcase
  end

  // address of the final beat of a burst starting here
  assign last_addr = bus_req.haddr + ((addr_t'(burst_len) - addr_t'(1)) << 2);

  // beats still owed by the burst in progress
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      beats_left_q <= '0;
    end else if (bus_rsp.hready && bus_req.htrans == TRANS_NONSEQ) begin
      beats_left_q <= burst_len - 1'b1;
    end else if (bus_rsp.hready && bus_req.htrans == TRANS_SEQ) begin
      beats_left_q <= beats_left_q - 1'b1;
    end
  end

  // ------------------------------
  a_hold: assert property (@(posedge clk) disable iff (!rst)
    !bus_rsp.hready |=> $stable(bus_req.haddr) && $stable(bus_req.htrans))
    else begin
      fail_cnt++;
      $error("address phase changed during a wait state");
    end

  a_seq_inside: assert property (@(posedge clk) disable iff (!rst)
    bus_req.htrans == TRANS_SEQ |-> beats_left_q != '0)
    else begin
      fail_cnt++;
      $error("SEQ beat outside a burst");
    end

  a_burst_continues: assert property (@(posedge clk) disable iff (!rst)
    beats_left_q != '0 |-> bus_req.htrans == TRANS_SEQ)
    else begin
      fail_cnt++;
      $error("burst beat not issued as SEQ");
    end

  a_no_1k_cross: assert property (@(posedge clk) disable iff (!rst)
    bus_req.htrans == TRANS_NONSEQ |-> last_addr[31:10] == bus_req.haddr[31:10])
    else begin
      fail_cnt++;
      $error("burst crosses a 1 KB boundary");
    end

  a_ack_done: assert property (@(posedge clk) disable iff (!rst) !(req_ack && done))
    else begin
      fail_cnt++;
      $error("req_ack and done high together");
    end

endmodule

bind ahb_burst_master ahb_xfer_assertions u_assertions (
  .clk     (clk),
  .rst     (rst),
  .bus_req (bus_req),
  .bus_rsp (bus_rsp),
  .req_ack (req_ack),
  .done    (done)
);

`default_nettype wire

/* tb/ahb_xfer_tb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "ahb_defs.svh"

module ahb_xfer_tb
  import ahb_pkg::*;
();

  localparam int NUM_CMDS     = 40;
  localparam int MAX_WORDS    = 40;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  // three cycles per beat at worst plus handshake and gap cycles
  localparam int WATCHDOG_NS  = NUM_CMDS * (MAX_WORDS + 1) * 3 * CLK_PERIOD
                              + NUM_CMDS * 12 * CLK_PERIOD + 100 * CLK_PERIOD;

  logic      clk;
  logic      rst;
  xfer_cmd_t cmd;
  logic      req;
  logic      req_ack;
  logic      done;
  data_t     wdata;
  logic      wdata_ready;
  data_t     rdata;
  logic      rdata_valid;

  addr_t cmd_addr  [NUM_CMDS];
  int    cmd_words [NUM_CMDS];
  logic  cmd_wr    [NUM_CMDS];
  int    write_ids [$];
  // write words not yet taken by the DUT
  data_t wr_words [$];
  data_t model [int];

  logic  in_window;
  addr_t cur_addr;
  int    wr_cnt;
  int    rd_cnt;
  int    stray_cnt;
  int    check_cnt;
  int    err_cnt;

  ahb_xfer_top UUT (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .req         (req),
    .req_ack     (req_ack),
    .done        (done),
    .wdata       (wdata),
    .wdata_ready (wdata_ready),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the commands did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_word(input data_t got, input data_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input byte_cnt_t got, input byte_cnt_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic pick_cmd(input int i);
    int words;
    int start_word;
    int j;
    int off;
    if (i % 8 == 3) begin
      // last word of a 1 KB window
      cmd_wr[i]  = 1'b1;
      words      = 2 + $urandom_range(MAX_WORDS - 2);
      start_word = $urandom_range(14) * 256 + 255;
    end else if (i % 8 == 4) begin
      // read back the boundary write
      cmd_wr[i]  = 1'b0;
      words      = cmd_words[i - 1];
      start_word = cmd_addr[i - 1] >> 2;
    end else if (write_ids.size() == 0 || $urandom_range(1) == 0) begin
      cmd_wr[i]  = 1'b1;
      words      = 1 + $urandom_range(MAX_WORDS - 1);
      start_word = $urandom_range(`SRAM_WORDS - words);
    end else begin
      j          = write_ids[$urandom_range(write_ids.size() - 1)];
      off        = $urandom_range(cmd_words[j] - 1);
      cmd_wr[i]  = 1'b0;
      words      = 1 + $urandom_range(cmd_words[j] - off - 1);
      start_word = (cmd_addr[j] >> 2) + off;
    end
    cmd_words[i] = words;
    cmd_addr[i]  = addr_t'(start_word) << 2;
    if (cmd_wr[i]) begin
      write_ids.push_back(i);
      repeat (words) wr_words.push_back($urandom());
    end
  endtask

  task automatic raise_req(input int i);
    cmd.start_addr = cmd_addr[i];
    cmd.byte_cnt   = byte_cnt_t'(cmd_words[i] * 4);
    cmd.wr         = cmd_wr[i];
    req            = 1'b1;
    wdata          = (wr_words.size() > 0) ? wr_words[0] : '0;
  endtask

  // one cycle sampled and driven on the falling edge
  task automatic step_cycle();
    int idx;
    @(negedge clk);
    if (wdata_ready) begin
      if (in_window && wr_words.size() > 0) begin
        idx        = (cur_addr >> 2) + wr_cnt;
        model[idx] = wr_words.pop_front();
        wr_cnt++;
      end else begin
        stray_cnt++;
      end
    end
    if (rdata_valid && in_window) begin
      idx = (cur_addr >> 2) + rd_cnt;
      if (model.exists(idx)) begin
        check_word(rdata, model[idx], $sformatf("read of word %0d", idx));
      end else begin
        err_cnt++;
        $display("read at %0t ns of word %0d that no write has covered", $time, idx);
      end
      rd_cnt++;
    end else if (rdata_valid) begin
      stray_cnt++;
    end
    if (!in_window && (done || (req_ack && !req))) stray_cnt++;
    wdata = (wr_words.size() > 0) ? wr_words[0] : '0;
  endtask

  task automatic run_cmd(input int i, output logic next_raised);
    int acks;
    int ticks;
    int errs_before;
    errs_before = err_cnt;
    next_raised = 1'b0;
    step_cycle();
    while (!req_ack) step_cycle();
    check_flag(done, 1'b0, "done together with req_ack");
    req       = 1'b0;
    cur_addr  = cmd_addr[i];
    wr_cnt    = 0;
    rd_cnt    = 0;
    acks      = 0;
    ticks     = 0;
    in_window = 1'b1;
    step_cycle();
    while (!done) begin
      if (req_ack) acks++;
      ticks++;
      // next command raised early and held
      if (i % 4 == 1 && i + 1 < NUM_CMDS && ticks == 2) begin
        pick_cmd(i + 1);
        raise_req(i + 1);
        next_raised = 1'b1;
      end
      step_cycle();
    end
    in_window = 1'b0;
    check_flag(req_ack, 1'b0, "req_ack together with done");
    check_count(byte_cnt_t'(acks), '0, "req_ack pulses while busy");
    check_count(byte_cnt_t'(wr_cnt), byte_cnt_t'(cmd_wr[i] ? cmd_words[i] : 0),
                "wdata_ready pulses");
    check_count(byte_cnt_t'(rd_cnt), byte_cnt_t'(cmd_wr[i] ? 0 : cmd_words[i]),
                "rdata_valid pulses");
    check_count(byte_cnt_t'(stray_cnt), '0, "pulses outside a command");
    stray_cnt = 0;
    $display("cmd %0d %s addr 0x%08h words %0d %s", i, cmd_wr[i] ? "write" : "read",
             cmd_addr[i], cmd_words[i], (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  initial begin : main_seq
    int   seed_val;
    int   gap;
    logic next_raised;
    seed_val  = 37;
    gap       = $urandom(seed_val);
    rst       = 1'b0;
    req       = 1'b0;
    cmd       = '0;
    wdata     = '0;
    in_window = 1'b0;
    stray_cnt = 0;
    check_cnt = 0;
    err_cnt   = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b1;
    repeat (2) step_cycle();
    pick_cmd(0);
    raise_req(0);
    for (int i = 0; i < NUM_CMDS; i++) begin
      run_cmd(i, next_raised);
      if (i + 1 < NUM_CMDS && !next_raised) begin
        gap = $urandom_range(3);
        repeat (gap) step_cycle();
        pick_cmd(i + 1);
        raise_req(i + 1);
      end
    end
    repeat (10) step_cycle();
    check_count(byte_cnt_t'(stray_cnt), '0, "pulses after the last command");
    check_count(byte_cnt_t'(UUT.u_master.u_assertions.fail_cnt), '0,
                "bus protocol assertion failures");
    $display("%0d commands, %0d checks, %0d errors", NUM_CMDS, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ahb_xfer_top.f */
+incdir+verilog
verilog/ahb_pkg.sv
verilog/burst_planner.sv
verilog/ahb_burst_master.sv
verilog/ahb_sram_slave.sv
verilog/ahb_xfer_top.sv
tb/ahb_xfer_assertions.sv
tb/ahb_xfer_tb.sv
